/* rtl/clkLanePkg.sv */
// Shared types, line codes and default phase durations for the D-PHY clock lane transmitter
package clkLanePkg;

    // Width of every phase duration count
    localparam int CNT_W = 12;

    // Line codes driven onto the clock lane
    typedef enum logic [2:0] {
        OFF,
        LP11,
        LP10,
        LP01,
        LP00,
        HS0,
        HS1
    } lineState_t;

    // PPI requests from the protocol layer
    typedef struct packed {
        logic enable;
        logic txRequestHs;
        logic txUlpsClk;
        logic txUlpsExit;
    } ppiCtrl_t;

    // PPI status back to the protocol layer
    typedef struct packed {
        logic stopState;
        logic txReadyHs;
        logic ulpsActiveNot;
    } ppiStatus_t;

    // One entry per programmable duration
    typedef enum logic [3:0] {
        INIT,
        LPX,
        CLK_PREPARE,
        CLK_ZERO,
        CLK_PRE,
        CLK_POST,
        CLK_TRAIL,
        HS_EXIT,
        WAKEUP
    } timingSel_t;

    // CLK_PRE and CLK_POST count HS clock periods, all others count cycles
    typedef struct packed {
        logic [CNT_W-1:0] init;
        logic [CNT_W-1:0] lpx;
        logic [CNT_W-1:0] clkPrepare;
        logic [CNT_W-1:0] clkZero;
        logic [CNT_W-1:0] clkPre;
        logic [CNT_W-1:0] clkPost;
        logic [CNT_W-1:0] clkTrail;
        logic [CNT_W-1:0] hsExit;
        logic [CNT_W-1:0] wakeup;
    } laneTiming_t;

    // Single register write carried by the req/ack port
    typedef struct packed {
        timingSel_t       sel;
        logic [CNT_W-1:0] value;
    } cfgWrite_t;

    localparam laneTiming_t DEFAULT_TIMING = '{
        init:       12'd20,
        lpx:        12'd4,
        clkPrepare: 12'd3,
        clkZero:    12'd10,
        clkPre:     12'd4,
        clkPost:    12'd6,
        clkTrail:   12'd5,
        hsExit:     12'd6,
        wakeup:     12'd30
    };

endpackage

/* rtl/laneTimingRegs.sv */
// Phase duration registers for the clock lane, written one field at a time over a req/ack port
`timescale 1ns/1ps

module laneTimingRegs (
    input  logic                    ppi,
    input  logic                    hsClk,
    input  logic                    cfgReq,
    input  clkLanePkg::cfgWrite_t   cfgWrite,
    output logic                    cfgAck,
    output clkLanePkg::laneTiming_t timing
);
    import clkLanePkg::*;

    logic writeEn;

    // New request seen while idle, so this edge writes and acknowledges
    assign writeEn = cfgReq && !cfgAck;

    // Four-phase handshake where ack follows req one cycle later in both directions
    always_ff @(posedge ppi or negedge hsClk)
    begin
        if (!hsClk)
        begin
            cfgAck <= 1'b0;
        end
        else if (writeEn)
        begin
            cfgAck <= 1'b1;
        end
        else if (!cfgReq)
        begin
            cfgAck <= 1'b0;
        end
    end

    always_ff @(posedge ppi or negedge hsClk)
    begin
        if (!hsClk)
        begin
            timing <= DEFAULT_TIMING;
        end
        else if (writeEn)
        begin
            case (cfgWrite.sel)
                INIT:        timing.init       <= cfgWrite.value;
                LPX:         timing.lpx        <= cfgWrite.value;
                CLK_PREPARE: timing.clkPrepare <= cfgWrite.value;
                CLK_ZERO:    timing.clkZero    <= cfgWrite.value;
                CLK_PRE:     timing.clkPre     <= cfgWrite.value;
                CLK_POST:    timing.clkPost    <= cfgWrite.value;
                CLK_TRAIL:   timing.clkTrail   <= cfgWrite.value;
                HS_EXIT:     timing.hsExit     <= cfgWrite.value;
                WAKEUP:      timing.wakeup     <= cfgWrite.value;
                default:     timing            <= timing;
            endcase
        end
    end

    // Master keeps the write word steady until it releases the request
    cfgStable: assert property (@(posedge ppi) disable iff (!hsClk)
        cfgReq && !cfgAck |=> !cfgReq || $stable(cfgWrite))
        else $error("cfgWrite changed during an open request");

    // A zero duration would wrap the phase counter
    cfgNonZero: assert property (@(posedge ppi) disable iff (!hsClk)
        writeEn |-> cfgWrite.value != '0)
        else $error("Zero duration written to the timing registers");

endmodule

/* rtl/laneTimer.sv */
// Phase down-counter for the clock lane, loaded with the duration picked by the state machine
`timescale 1ns/1ps

module laneTimer (
    input  logic                    ppi,
    input  logic                    hsClk,
    input  clkLanePkg::laneTiming_t timing,
    input  logic                    load,
    input  clkLanePkg::timingSel_t  sel,
    output logic                    done
);
    import clkLanePkg::*;

    // One extra bit holds the doubled HS burst counts
    logic [CNT_W:0] loadVal;
    logic [CNT_W:0] cnt;
    logic           active;

    always_comb
    begin
        case (sel)
            INIT:        loadVal = {1'b0, timing.init};
            LPX:         loadVal = {1'b0, timing.lpx};
            CLK_PREPARE: loadVal = {1'b0, timing.clkPrepare};
            CLK_ZERO:    loadVal = {1'b0, timing.clkZero};
            // Burst lengths are HS periods of two line cycles each
            CLK_PRE:     loadVal = {timing.clkPre, 1'b0};
            CLK_POST:    loadVal = {timing.clkPost, 1'b0};
            CLK_TRAIL:   loadVal = {1'b0, timing.clkTrail};
            HS_EXIT:     loadVal = {1'b0, timing.hsExit};
            WAKEUP:      loadVal = {1'b0, timing.wakeup};
            default:     loadVal = {1'b0, timing.lpx};
        endcase
    end

    // Counts N-1 down to 0 so a load of N spans N cycles
    always_ff @(posedge ppi or negedge hsClk)
    begin
        if (!hsClk)
        begin
            cnt    <= '0;
            active <= 1'b0;
        end
        else if (load)
        begin
            cnt    <= loadVal - 1'b1;
            active <= 1'b1;
        end
        else if (done)
        begin
            active <= 1'b0;
        end
        else if (active)
        begin
            cnt <= cnt - 1'b1;
        end
    end

    assign done = active && (cnt == '0);

    // State machine only moves to a new phase once the current one ends
    loadAtEnd: assert property (@(posedge ppi) disable iff (!hsClk)
        load |-> !active || done)
        else $error("Timer reloaded in the middle of a phase");

endmodule

/* rtl/clkLaneFsm.sv */
// Clock lane state machine sequencing LP, HS and ULPS phases and driving the line and PPI status
`timescale 1ns/1ps

module clkLaneFsm (
    input  logic                   ppi,
    input  logic                   hsClk,
    input  clkLanePkg::ppiCtrl_t   ctrl,
    input  logic                   done,
    output logic                   load,
    output clkLanePkg::timingSel_t sel,
    output clkLanePkg::lineState_t line,
    output clkLanePkg::ppiStatus_t status
);
    import clkLanePkg::*;

    typedef enum logic [3:0] {
        Off, Init, Stop,
        HsLpx, HsPrepare, HsZero, HsPre, HsTx, HsPost, HsTrail, HsExit,
        UlpsEntry, Ulps, UlpsWake
    } fsmState_t;

    fsmState_t  state;
    fsmState_t  nextState;
    lineState_t nextLine;
    ppiStatus_t nextStatus;
    logic       hsPhase;
    logic       wakeDone;

    always_comb
    begin
        nextState = state;
        load      = 1'b0;
        sel       = INIT;
        // Shutdown wins over everything
        if (!ctrl.enable)
        begin
            nextState = Off;
        end
        else
        begin
            case (state)
                Off:
                begin
                    nextState = Init;
                    load      = 1'b1;
                    sel       = INIT;
                end
                Init:
                    if (done)
                        nextState = Stop;
                Stop:
                begin
                    if (ctrl.txRequestHs)
                    begin
                        nextState = HsLpx;
                        load      = 1'b1;
                        sel       = LPX;
                    end
                    else if (ctrl.txUlpsClk)
                    begin
                        nextState = UlpsEntry;
                        load      = 1'b1;
                        sel       = LPX;
                    end
                end
                HsLpx:
                    if (done)
                    begin
                        nextState = HsPrepare;
                        load      = 1'b1;
                        sel       = CLK_PREPARE;
                    end
                HsPrepare:
                    if (done)
                    begin
                        nextState = HsZero;
                        load      = 1'b1;
                        sel       = CLK_ZERO;
                    end
                HsZero:
                    if (done)
                    begin
                        nextState = HsPre;
                        load      = 1'b1;
                        sel       = CLK_PRE;
                    end
                HsPre:
                    if (done)
                        nextState = HsTx;
                // Leave only after an HS0 so the post burst opens with HS1
                HsTx:
                    if (!ctrl.txRequestHs && line == HS0)
                    begin
                        nextState = HsPost;
                        load      = 1'b1;
                        sel       = CLK_POST;
                    end
                HsPost:
                    if (done)
                    begin
                        nextState = HsTrail;
                        load      = 1'b1;
                        sel       = CLK_TRAIL;
                    end
                HsTrail:
                    if (done)
                    begin
                        nextState = HsExit;
                        load      = 1'b1;
                        sel       = HS_EXIT;
                    end
                HsExit:
                    if (done)
                        nextState = Stop;
                UlpsEntry:
                    if (done)
                        nextState = Ulps;
                Ulps:
                    if (ctrl.txUlpsExit)
                    begin
                        nextState = UlpsWake;
                        load      = 1'b1;
                        sel       = WAKEUP;
                    end
                // Mark holds at least the wakeup time, then until the ULPS request drops
                UlpsWake:
                    if ((done || wakeDone) && !ctrl.txUlpsClk)
                        nextState = Stop;
                default:
                    nextState = Off;
            endcase
        end
    end

    // Line and status for the cycle that nextState occupies
    always_comb
    begin
        nextLine                 = OFF;
        nextStatus               = '0;
        nextStatus.ulpsActiveNot = 1'b1;
        case (nextState)
            Off:       nextStatus.ulpsActiveNot = 1'b0;
            Init:      nextLine = LP11;
            Stop:
            begin
                nextLine             = LP11;
                nextStatus.stopState = 1'b1;
            end
            HsLpx:     nextLine = LP01;
            HsPrepare: nextLine = LP00;
            HsZero:    nextLine = HS0;
            HsPre:     nextLine = hsPhase ? HS1 : HS0;
            HsTx, HsPost:
            begin
                nextLine             = hsPhase ? HS1 : HS0;
                nextStatus.txReadyHs = 1'b1;
            end
            HsTrail:   nextLine = HS0;
            HsExit:    nextLine = LP11;
            UlpsEntry: nextLine = LP10;
            Ulps:
            begin
                nextLine                 = LP00;
                nextStatus.ulpsActiveNot = 1'b0;
            end
            UlpsWake:  nextLine = LP10;
            default:   nextLine = OFF;
        endcase
    end

    always_ff @(posedge ppi or negedge hsClk)
    begin
        if (!hsClk)
        begin
            state    <= Off;
            line     <= OFF;
            status   <= '0;
            hsPhase  <= 1'b1;
            wakeDone <= 1'b0;
        end
        else
        begin
            state  <= nextState;
            line   <= nextLine;
            status <= nextStatus;
            // HS toggle parks at HS1 so every burst starts high
            if (nextState inside {HsPre, HsTx, HsPost})
                hsPhase <= ~hsPhase;
            else
                hsPhase <= 1'b1;
            if (nextState != UlpsWake)
                wakeDone <= 1'b0;
            else if (done)
                wakeDone <= 1'b1;
        end
    end

    // HS and ULPS are mutually exclusive requests
    stopExclusive: assert property (@(posedge ppi) disable iff (!hsClk)
        state == Stop |-> !(ctrl.txRequestHs && ctrl.txUlpsClk))
        else $error("HS and ULPS requested together in Stop");

    hsReqHeld: assert property (@(posedge ppi) disable iff (!hsClk)
        state inside {HsLpx, HsPrepare, HsZero, HsPre} && ctrl.enable |-> ctrl.txRequestHs)
        else $error("txRequestHs dropped during HS start-up");

    ulpsReqHeld: assert property (@(posedge ppi) disable iff (!hsClk)
        ctrl.enable && state inside {UlpsEntry, Ulps} |-> ctrl.txUlpsClk)
        else $error("txUlpsClk dropped before the wakeup mark");

endmodule

/* rtl/mipiClkLaneTx.sv */
// Top level of the D-PHY master clock lane transmitter, joining timing registers, timer and FSM
`timescale 1ns/1ps

module mipiClkLaneTx (
    input  logic                   ppi,
    input  logic                   hsClk,
    input  logic                   cfgReq,
    input  clkLanePkg::cfgWrite_t  cfgWrite,
    output logic                   cfgAck,
    input  clkLanePkg::ppiCtrl_t   ctrl,
    output clkLanePkg::ppiStatus_t status,
    output clkLanePkg::lineState_t line
);

    clkLanePkg::laneTiming_t timing;
    clkLanePkg::timingSel_t  sel;
    logic                    load;
    logic                    done;

    laneTimingRegs i_regs (
        .ppi      (ppi),
        .hsClk    (hsClk),
        .cfgReq   (cfgReq),
        .cfgWrite (cfgWrite),
        .cfgAck   (cfgAck),
        .timing   (timing)
    );

    laneTimer i_timer (
        .ppi    (ppi),
        .hsClk  (hsClk),
        .timing (timing),
        .load   (load),
        .sel    (sel),
        .done   (done)
    );

    clkLaneFsm i_fsm (
        .ppi    (ppi),
        .hsClk  (hsClk),
        .ctrl   (ctrl),
        .done   (done),
        .load   (load),
        .sel    (sel),
        .line   (line),
        .status (status)
    );

endmodule

/* verif/tbClkLane.sv */
// Table-driven testbench for the clock lane transmitter, run through Verilator via the Makefile
`timescale 1ns/1ps

module tbClkLane;
    import clkLanePkg::*;

    localparam int NUM_ROWS  = 6;
    localparam int MODE_HS   = 0;
    localparam int MODE_ULPS = 1;
    localparam int LOOP_MAX  = 4096;

    // INIT LPX CLK_PREPARE CLK_ZERO CLK_PRE CLK_POST CLK_TRAIL HS_EXIT WAKEUP mode
    localparam int ROWS [NUM_ROWS][10] = '{
        '{20, 4, 3, 10, 4, 6, 5, 6, 30, MODE_HS},
        '{20, 4, 3, 10, 4, 6, 5, 6, 30, MODE_ULPS},
        '{14, 2, 5, 7, 3, 2, 4, 3, 9, MODE_HS},
        '{14, 6, 1, 3, 1, 1, 2, 1, 12, MODE_ULPS},
        '{9, 1, 1, 2, 1, 1, 1, 1, 5, MODE_HS},
        '{9, 3, 2, 4, 2, 3, 2, 2, 6, MODE_ULPS}
    };

    // Power-on durations of the register block
    localparam int DEFAULTS [9] = '{20, 4, 3, 10, 4, 6, 5, 6, 30};

    typedef struct packed {
        lineState_t line;
        ppiStatus_t status;
    } lineSample_t;

    logic        ppi;
    logic        hsClk;
    logic        cfgReq;
    cfgWrite_t   cfgWrite;
    logic        cfgAck;
    ppiCtrl_t    ctrl;
    ppiStatus_t  status;
    lineState_t  line;

    int          errCount;
    int          checkCount;
    int          cur [9];
    logic [7:0]  lfsrState;
    lineSample_t expVal [$];
    int          expLen [$];
    lineSample_t obsVal [$];
    int          obsLen [$];

    mipiClkLaneTx i_dut (
        .ppi      (ppi),
        .hsClk    (hsClk),
        .cfgReq   (cfgReq),
        .cfgWrite (cfgWrite),
        .cfgAck   (cfgAck),
        .ctrl     (ctrl),
        .status   (status),
        .line     (line)
    );

    initial
    begin
        ppi = 1'b0;
        forever #4 ppi = ~ppi;
    end

    // Taps 8 6 5 4
    function automatic logic [7:0] lfsrStep(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic int holdLength();
        logic [3:0] v;
        int         b;
        v = '0;
        for (b = 0; b < 4; b++)
        begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[2:0], lfsrState[0]};
        end
        return int'(v) + 2;
    endfunction

    function automatic lineSample_t sampleOf(input lineState_t l, input logic [2:0] s);
        return {l, s};
    endfunction

    task automatic compareValue(input string name, input int got, input int exp);
        checkCount++;
        assert (got == exp) else
        begin
            errCount++;
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic confirm(input logic cond, input string msg);
        checkCount++;
        assert (cond) else
        begin
            errCount++;
            $display("%s", msg);
        end
    endtask

    task automatic appendRun(input lineSample_t v, input int len);
        if (len > 0)
        begin
            expVal.push_back(v);
            expLen.push_back(len);
        end
    endtask

    // HS bursts open with HS1 and alternate every cycle
    task automatic toggleRuns(input int n, input logic [2:0] s);
        int k;
        for (k = 0; k < n; k++)
            appendRun(sampleOf((k % 2 == 0) ? HS1 : HS0, s), 1);
    endtask

    task automatic logSample(input lineSample_t v);
        if (obsVal.size() > 0 && obsVal[obsVal.size()-1] == v)
            obsLen[obsLen.size()-1] = obsLen[obsLen.size()-1] + 1;
        else
        begin
            obsVal.push_back(v);
            obsLen.push_back(1);
        end
    endtask

    task automatic matchRuns(input string scen);
        int n;
        int k;
        checkCount++;
        assert (obsVal.size() == expVal.size()) else
        begin
            errCount++;
            $display("%s sequence has a missing or extra phase, saw %0d phases, expected %0d",
                scen, obsVal.size(), expVal.size());
        end
        n = (obsVal.size() < expVal.size()) ? obsVal.size() : expVal.size();
        for (k = 0; k < n; k++)
        begin
            checkCount++;
            assert (obsVal[k] == expVal[k] && obsLen[k] == expLen[k]) else
            begin
                errCount++;
                $display("** Error line/status %s run %0d: got 0x%0h x 0x%0h, expected 0x%0h x 0x%0h",
                    scen, k, obsVal[k], obsLen[k], expVal[k], expLen[k]);
            end
        end
        expVal.delete();
        expLen.delete();
        obsVal.delete();
        obsLen.delete();
    endtask

    task automatic writeTiming(input int idx, input int value);
        int waited;
        @(negedge ppi);
        confirm(!cfgAck, "cfgAck was already high before the request was raised");
        cfgWrite.sel   = timingSel_t'(idx[3:0]);
        cfgWrite.value = 12'(value);
        cfgReq         = 1'b1;
        waited         = 0;
        do
        begin
            @(negedge ppi);
            waited++;
        end
        while (!cfgAck && waited < 16);
        confirm(cfgAck, "Config handshake stalled, cfgAck never rose");
        compareValue("cfgAck rise delay", waited, 1);
        // Ack must hold while the request stays up
        @(negedge ppi);
        compareValue("cfgAck", int'(cfgAck), 1);
        cfgReq = 1'b0;
        waited = 0;
        do
        begin
            @(negedge ppi);
            waited++;
        end
        while (cfgAck && waited < 16);
        confirm(!cfgAck, "Config handshake stalled, cfgAck never fell");
        compareValue("cfgAck fall delay", waited, 1);
    endtask

    task automatic initPhase(input int initLen);
        int cnt;
        cnt = 0;
        @(negedge ppi);
        ctrl.enable = 1'b1;
        do
        begin
            @(negedge ppi);
            if (!status.stopState)
            begin
                cnt++;
                compareValue("line", int'(line), int'(LP11));
                compareValue("status", int'(status), 1);
            end
        end
        while (!status.stopState && cnt < LOOP_MAX);
        confirm(status.stopState, "Lane never reached Stop after init");
        compareValue("init LP11 cycles", cnt, initLen);
        compareValue("line", int'(line), int'(LP11));
    endtask

    task automatic hsScenario();
        int hold;
        int hsTx;
        int heldFor;
        int cyc;
        hold    = holdLength();
        // Exit is taken on the first HS0 cycle once the request is seen low
        hsTx    = (hold % 2 == 1) ? hold + 1 : hold + 2;
        heldFor = 0;
        cyc     = 0;
        appendRun(sampleOf(LP01, 3'b001), cur[1]);
        appendRun(sampleOf(LP00, 3'b001), cur[2]);
        appendRun(sampleOf(HS0, 3'b001), cur[3]);
        toggleRuns(2 * cur[4], 3'b001);
        toggleRuns(hsTx + 2 * cur[5], 3'b011);
        appendRun(sampleOf(HS0, 3'b001), cur[6]);
        appendRun(sampleOf(LP11, 3'b001), cur[7]);
        appendRun(sampleOf(LP11, 3'b101), 1);
        @(negedge ppi);
        ctrl.txRequestHs = 1'b1;
        do
        begin
            @(negedge ppi);
            logSample(sampleOf(line, status));
            if (ctrl.txRequestHs && status.txReadyHs)
            begin
                if (heldFor == hold)
                    ctrl.txRequestHs = 1'b0;
                else
                    heldFor++;
            end
            cyc++;
        end
        while (!status.stopState && cyc < LOOP_MAX);
        confirm(status.stopState, "HS burst never returned to Stop");
        matchRuns("HS");
    endtask

    task automatic ulpsScenario();
        int ulpsHold;
        int markHold;
        int markLen;
        int ulpsCnt;
        int wakeCnt;
        int cyc;
        ulpsHold = holdLength();
        markHold = holdLength();
        // Mark lasts the wakeup time even when txUlpsClk drops earlier
        markLen  = (markHold > cur[8]) ? markHold : cur[8];
        ulpsCnt  = 0;
        wakeCnt  = 0;
        cyc      = 0;
        appendRun(sampleOf(LP10, 3'b001), cur[1]);
        appendRun(sampleOf(LP00, 3'b000), ulpsHold);
        appendRun(sampleOf(LP10, 3'b001), markLen);
        appendRun(sampleOf(LP11, 3'b101), 1);
        @(negedge ppi);
        ctrl.txUlpsClk = 1'b1;
        do
        begin
            @(negedge ppi);
            logSample(sampleOf(line, status));
            if (line == LP00 && !status.ulpsActiveNot)
            begin
                if (ulpsCnt == ulpsHold - 1)
                    ctrl.txUlpsExit = 1'b1;
                ulpsCnt++;
            end
            else if (ctrl.txUlpsExit && line == LP10)
            begin
                if (wakeCnt == markHold - 1)
                begin
                    ctrl.txUlpsClk  = 1'b0;
                    ctrl.txUlpsExit = 1'b0;
                end
                wakeCnt++;
            end
            cyc++;
        end
        while (!status.stopState && cyc < LOOP_MAX);
        confirm(status.stopState, "ULPS sequence never returned to Stop");
        matchRuns("ULPS");
    endtask

    task automatic enableDropTest();
        int cnt;
        cnt = 0;
        @(negedge ppi);
        ctrl.txRequestHs = 1'b1;
        do
        begin
            @(negedge ppi);
            cnt++;
        end
        while (!status.txReadyHs && cnt < LOOP_MAX);
        confirm(status.txReadyHs, "HS start-up never raised txReadyHs");
        repeat (3) @(negedge ppi);
        ctrl.enable      = 1'b0;
        ctrl.txRequestHs = 1'b0;
        @(negedge ppi);
        compareValue("line", int'(line), int'(OFF));
        compareValue("status", int'(status), 0);
        // Re-init uses the last written INIT
        initPhase(cur[0]);
    endtask

    initial
    begin
        int r;
        int i;
        errCount   = 0;
        checkCount = 0;
        lfsrState  = 8'd35;
        hsClk      = 1'b0;
        cfgReq     = 1'b0;
        cfgWrite   = '0;
        ctrl       = '0;
        for (i = 0; i < 9; i++)
            cur[i] = DEFAULTS[i];
        repeat (3) @(posedge ppi);
        @(negedge ppi);
        hsClk = 1'b1;
        @(negedge ppi);
        compareValue("line", int'(line), int'(OFF));
        compareValue("status", int'(status), 0);
        compareValue("cfgAck", int'(cfgAck), 0);
        initPhase(cur[0]);
        for (r = 0; r < NUM_ROWS; r++)
        begin
            for (i = 0; i < 9; i++)
            begin
                if (ROWS[r][i] != cur[i])
                begin
                    writeTiming(i, ROWS[r][i]);
                    cur[i] = ROWS[r][i];
                end
            end
            if (ROWS[r][9] == MODE_HS)
                hsScenario();
            else
                ulpsScenario();
        end
        enableDropTest();
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    // Watchdog sized from the table
    initial
    begin
        int limit;
        int r;
        int i;
        limit = 1000;
        for (r = 0; r < NUM_ROWS; r++)
            for (i = 0; i < 9; i++)
                limit += 2 * ROWS[r][i];
        repeat (limit) @(posedge ppi);
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

/* sources.f */
rtl/clkLanePkg.sv
rtl/laneTimingRegs.sv
rtl/laneTimer.sv
rtl/clkLaneFsm.sv
rtl/mipiClkLaneTx.sv
verif/tbClkLane.sv

/* Makefile */
SRCS := sources.f $(wildcard rtl/*.sv) $(wildcard verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/VtbClkLane: $(SRCS)
	verilator --binary --timing --assert --top-module tbClkLane -Mdir obj_dir -f sources.f

run: obj_dir/VtbClkLane
	./obj_dir/VtbClkLane > sim.log 2>&1; cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
